//--- Makefile
VERILATOR := verilator
TOP       := mem_subsystem_tb
FILELIST  := mem_subsystem.f
VFLAGS    := --binary --assert -j 0 --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Test completed successfully

SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   := $(wildcard common/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// number of store buffer entries. 2, 8 and 16 work as well.
`define STBUF_DEPTH 4

// data memory size in words.
`define MEM_WORDS 64

// address and data widths of the memory path.
`define ADDR_WIDTH 32
`define DATA_WIDTH 32

`endif

//--- common/mem_pkg.sv
`default_nettype none

`include "mem_config.svh"

package mem_pkg;

  // --------------------
  // derived sizes
  // --------------------

  localparam int SB_IDX_W = $clog2(`STBUF_DEPTH);
  localparam int MEM_INDEX_W = $clog2(`MEM_WORDS);

  // --------------------
  // shared types
  // --------------------

  // word address. the memory only looks at the low index bits.
  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  typedef logic [`DATA_WIDTH-1:0] data_t;

  // position of an entry inside the store buffer, 0 is the oldest.
  typedef logic [SB_IDX_W-1:0] sb_index_t;

  // the extra bit lets the count reach STBUF_DEPTH itself.
  typedef logic [SB_IDX_W:0] sb_count_t;

  typedef logic [MEM_INDEX_W-1:0] mem_index_t;

endpackage

`default_nettype wire

//--- logic/data_memory.sv
`default_nettype none

`include "mem_config.svh"

module data_memory
  import mem_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire mem_index_t rd_index,
  input  wire logic       wr_en,
  input  wire mem_index_t wr_index,
  input  wire data_t      wr_data,
  output data_t           rd_data
);

  localparam int WORDS = `MEM_WORDS;

  data_t mem [WORDS];

  // the read samples the old word when it hits the location being written.
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_data <= '0;
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      rd_data <= mem[rd_index];
      if (wr_en) begin
        mem[wr_index] <= wr_data;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/load_return.sv
`default_nettype none

module load_return
  import mem_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire logic  load,
  input  wire logic  fwd_hit,
  input  wire data_t fwd_data,
  input  wire data_t rd_data,
  output logic       load_valid,
  output data_t      load_data
);

  logic  load_q;
  logic  hit_q;
  data_t fwd_q;

  // --------------------
  // load cycle capture
  // --------------------

  // the lookup result is captured at the same edge where the memory reads.
  always_ff @(posedge clk) begin
    if (reset) begin
      load_q <= 1'b0;
      hit_q  <= 1'b0;
    end else begin
      load_q <= load;
      hit_q  <= load & fwd_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      fwd_q <= fwd_data;
    end
  end

  // --------------------
  // return select
  // --------------------

  assign load_valid = load_q;

  // a buffered store is always newer than the memory word.
  assign load_data = hit_q ? fwd_q : rd_data;

endmodule

`default_nettype wire

//--- logic/mem_subsystem.sv
`default_nettype none

module mem_subsystem
  import mem_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire logic  load,
  input  wire logic  store,
  input  wire logic  alu_op,
  input  wire addr_t addr,
  input  wire data_t wdata,
  output logic       load_valid,
  output data_t      load_data,
  output logic       stall,
  output logic       mem_write,
  output addr_t      mem_write_addr,
  output data_t      mem_write_data
);

  logic       fwd_hit;
  data_t      fwd_data;
  logic       drain_valid;
  addr_t      drain_addr;
  data_t      drain_data;
  data_t      rd_data;
  mem_index_t rd_index;
  mem_index_t wr_index;

  // the memory is word addressed, so only the low address bits select a word.
  assign rd_index = addr[MEM_INDEX_W-1:0];
  assign wr_index = drain_addr[MEM_INDEX_W-1:0];

  // --------------------
  // store buffer
  // --------------------

  store_buffer u_store_buffer (
    .clk         (clk),
    .reset       (reset),
    .load        (load),
    .store       (store),
    .alu_op      (alu_op),
    .addr        (addr),
    .wdata       (wdata),
    .fwd_hit     (fwd_hit),
    .fwd_data    (fwd_data),
    .drain_valid (drain_valid),
    .drain_addr  (drain_addr),
    .drain_data  (drain_data),
    .stall       (stall)
  );

  // --------------------
  // data memory
  // --------------------

  data_memory u_data_memory (
    .clk      (clk),
    .reset    (reset),
    .rd_index (rd_index),
    .wr_en    (drain_valid),
    .wr_index (wr_index),
    .wr_data  (drain_data),
    .rd_data  (rd_data)
  );

  // --------------------
  // load return
  // --------------------

  load_return u_load_return (
    .clk        (clk),
    .reset      (reset),
    .load       (load),
    .fwd_hit    (fwd_hit),
    .fwd_data   (fwd_data),
    .rd_data    (rd_data),
    .load_valid (load_valid),
    .load_data  (load_data)
  );

  // the drain port doubles as the visible memory write.
  assign mem_write      = drain_valid;
  assign mem_write_addr = drain_addr;
  assign mem_write_data = drain_data;

endmodule

`default_nettype wire

//--- mem_subsystem.f
+incdir+common
common/mem_pkg.sv
store_buffer/store_buffer.sv
logic/data_memory.sv
logic/load_return.sv
logic/mem_subsystem.sv
verif/mem_subsystem_assertions.sv
verif/mem_subsystem_tb.sv

//--- store_buffer/store_buffer.sv
`default_nettype none

`include "mem_config.svh"

module store_buffer
  import mem_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire logic  load,
  input  wire logic  store,
  input  wire logic  alu_op,
  input  wire addr_t addr,
  input  wire data_t wdata,
  output logic       fwd_hit,
  output data_t      fwd_data,
  output logic       drain_valid,
  output addr_t      drain_addr,
  output data_t      drain_data,
  output logic       stall
);

  localparam int DEPTH = `STBUF_DEPTH;

  // entries are kept in age order. slot 0 is the oldest and slot count_q-1 the youngest.
  addr_t     addr_q [DEPTH];
  data_t     data_q [DEPTH];
  sb_count_t count_q;

  logic      do_store;
  logic      do_alu;
  logic      full;
  logic      empty;
  logic      append;
  logic      evict;
  logic      retire;
  sb_index_t tail;

  // --------------------
  // operation decode
  // --------------------

  // only one operation per cycle. a load masks a store, and both mask an ALU slot.
  assign do_store = store & ~load;
  assign do_alu   = alu_op & ~load & ~store;

  assign full  = (count_q == sb_count_t'(DEPTH));
  assign empty = (count_q == '0);

  assign append = do_store & ~full;
  assign evict  = do_store & full;
  assign retire = do_alu & ~empty;

  // the first free slot. only used while the buffer is not full.
  assign tail = count_q[SB_IDX_W-1:0];

  // --------------------
  // entry queue
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      count_q     <= '0;
      drain_valid <= 1'b0;
      drain_addr  <= '0;
      drain_data  <= '0;
      stall       <= 1'b0;
      for (int i = 0; i < DEPTH; i++) begin
        addr_q[i] <= '0;
        data_q[i] <= '0;
      end
    end else begin
      drain_valid <= evict | retire;
      // stall only tells the pipeline that memory was written on its behalf.
      stall       <= evict;

      // both eviction and retirement hand the oldest entry to memory.
      if (evict | retire) begin
        drain_addr <= addr_q[0];
        drain_data <= data_q[0];
        for (int i = 0; i < DEPTH - 1; i++) begin
          addr_q[i] <= addr_q[i+1];
          data_q[i] <= data_q[i+1];
        end
      end

      if (evict) begin
        // the count stays at DEPTH, the new store becomes the youngest entry.
        addr_q[DEPTH-1] <= addr;
        data_q[DEPTH-1] <= wdata;
      end else if (retire) begin
        addr_q[DEPTH-1] <= '0;
        data_q[DEPTH-1] <= '0;
        count_q         <= count_q - sb_count_t'(1);
      end else if (append) begin
        addr_q[tail] <= addr;
        data_q[tail] <= wdata;
        count_q      <= count_q + sb_count_t'(1);
      end
    end
  end

  // --------------------
  // load lookup
  // --------------------

  // the pending drain is checked first so that any buffer hit overrides it.
  // walking the slots from oldest to youngest leaves the youngest match in fwd_data.
  always_comb begin
    fwd_hit  = 1'b0;
    fwd_data = '0;
    if (drain_valid && (drain_addr == addr)) begin
      fwd_hit  = 1'b1;
      fwd_data = drain_data;
    end
    for (int i = 0; i < DEPTH; i++) begin
      if ((sb_count_t'(i) < count_q) && (addr_q[i] == addr)) begin
        fwd_hit  = 1'b1;
        fwd_data = data_q[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/mem_subsystem_assertions.sv
`default_nettype none

`include "mem_config.svh"

module mem_subsystem_assertions
  import mem_pkg::*;
(
  input wire logic      clk,
  input wire logic      reset,
  input wire logic      load,
  input wire logic      store,
  input wire logic      alu_op,
  input wire sb_count_t count_q,
  input wire logic      drain_valid,
  input wire logic      stall
);

  localparam int DEPTH = `STBUF_DEPTH;

  logic full_store;
  logic drain_event;

  // a load masks the store, and any store masks the ALU slot.
  assign full_store  = store & ~load & (count_q == sb_count_t'(DEPTH));
  assign drain_event = full_store | (alu_op & ~load & ~store & (count_q != '0));

  // --------------------
  // buffer rules
  // --------------------

  // every stall cycle, a second one in a row included, needs a full store just before it.
  stall_source: assert property (@(posedge clk) disable iff (reset)
    stall |-> $past(full_store))
    else $error("stall without a store to a full buffer in the cycle before");

  drain_follows_event: assert property (@(posedge clk) disable iff (reset)
    drain_event |=> drain_valid)
    else $error("drain event without drain_valid in the next cycle");

  drain_one_cycle: assert property (@(posedge clk) disable iff (reset)
    drain_valid |-> $past(drain_event))
    else $error("drain_valid high without a drain event in the cycle before");

  occupancy_bound: assert property (@(posedge clk) disable iff (reset)
    count_q <= sb_count_t'(DEPTH))
    else $error("store buffer occupancy above its depth");

endmodule

bind store_buffer mem_subsystem_assertions u_assertions (
  .clk         (clk),
  .reset       (reset),
  .load        (load),
  .store       (store),
  .alu_op      (alu_op),
  .count_q     (count_q),
  .drain_valid (drain_valid),
  .stall       (stall)
);

`default_nettype wire

//--- verif/mem_subsystem_tb.sv
`default_nettype none

module mem_subsystem_tb
  import mem_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  localparam int MAX_VECTORS = 256;

  logic  clk = 1'b0;
  logic  reset;
  logic  load;
  logic  store;
  logic  alu_op;
  addr_t addr;
  data_t wdata;
  logic  load_valid;
  data_t load_data;
  logic  stall;
  logic  mem_write;
  addr_t mem_write_addr;
  data_t mem_write_data;

  // one entry per vector line. the expected fields describe the cycle after the operation.
  logic [31:0] vec_op         [MAX_VECTORS];
  logic [31:0] vec_addr       [MAX_VECTORS];
  logic [31:0] vec_wdata      [MAX_VECTORS];
  logic [31:0] exp_stall      [MAX_VECTORS];
  logic [31:0] exp_write      [MAX_VECTORS];
  logic [31:0] exp_write_addr [MAX_VECTORS];
  logic [31:0] exp_write_data [MAX_VECTORS];
  logic [31:0] exp_valid      [MAX_VECTORS];
  logic [31:0] exp_load_data  [MAX_VECTORS];
  int          num_vectors    = 0;
  logic        vectors_loaded = 1'b0;

  mem_subsystem UUT (
    .clk            (clk),
    .reset          (reset),
    .load           (load),
    .store          (store),
    .alu_op         (alu_op),
    .addr           (addr),
    .wdata          (wdata),
    .load_valid     (load_valid),
    .load_data      (load_data),
    .stall          (stall),
    .mem_write      (mem_write),
    .mem_write_addr (mem_write_addr),
    .mem_write_data (mem_write_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------
  // helpers
  // --------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL time=%0t signal=%s actual=%h expected=%h", $time, name, actual, expected);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic read_vectors();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] f [9];
    fd = $fopen("verif/mem_subsystem_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("could not open verif/mem_subsystem_vectors.txt");
    end
    while ($fgets(line, fd) != 0) begin
      fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
      if (fields == 9 && num_vectors < MAX_VECTORS) begin
        vec_op[num_vectors]         = f[0];
        vec_addr[num_vectors]       = f[1];
        vec_wdata[num_vectors]      = f[2];
        exp_stall[num_vectors]      = f[3];
        exp_write[num_vectors]      = f[4];
        exp_write_addr[num_vectors] = f[5];
        exp_write_data[num_vectors] = f[6];
        exp_valid[num_vectors]      = f[7];
        exp_load_data[num_vectors]  = f[8];
        num_vectors++;
      end else if (fields > 0) begin
        abort_run($sformatf("bad or surplus line in the vector file: %s", line));
      end
    end
    $fclose(fd);
  endtask

  // the op field is a strobe mask. bit 0 is load, bit 1 store and bit 2 the ALU slot.
  task automatic apply_vector(input int i);
    load   = vec_op[i][0];
    store  = vec_op[i][1];
    alu_op = vec_op[i][2];
    addr   = vec_addr[i];
    wdata  = vec_wdata[i];
  endtask

  task automatic check_vector(input int i);
    check_value($sformatf("stall (vector %0d)", i), 32'(stall), exp_stall[i]);
    check_value($sformatf("mem_write (vector %0d)", i), 32'(mem_write), exp_write[i]);
    if (exp_write[i][0]) begin
      check_value($sformatf("mem_write_addr (vector %0d)", i), mem_write_addr,
                  exp_write_addr[i]);
      check_value($sformatf("mem_write_data (vector %0d)", i), mem_write_data,
                  exp_write_data[i]);
    end
    check_value($sformatf("load_valid (vector %0d)", i), 32'(load_valid), exp_valid[i]);
    if (exp_valid[i][0]) begin
      check_value($sformatf("load_data (vector %0d)", i), load_data, exp_load_data[i]);
    end
  endtask

  // --------------------
  // stimulus
  // --------------------

  initial begin
    reset  = 1'b1;
    load   = 1'b0;
    store  = 1'b0;
    alu_op = 1'b0;
    addr   = '0;
    wdata  = '0;
    read_vectors();
    if (num_vectors == 0) begin
      abort_run("the vector file holds no vectors");
    end
    vectors_loaded = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    check_value("stall after reset", 32'(stall), 32'd0);
    check_value("mem_write after reset", 32'(mem_write), 32'd0);
    check_value("load_valid after reset", 32'(load_valid), 32'd0);
    apply_vector(0);
    for (int i = 0; i < num_vectors; i++) begin
      @(negedge clk);
      check_vector(i);
      if (i + 1 < num_vectors) begin
        apply_vector(i + 1);
      end else begin
        load   = 1'b0;
        store  = 1'b0;
        alu_op = 1'b0;
      end
    end
    $display("Test completed successfully");
    $finish;
  end

  initial begin
    wait (vectors_loaded);
    #((num_vectors + 10) * CLK_PERIOD);
    abort_run("watchdog timeout: the vectors did not finish in time");
  end

endmodule

`default_nettype wire

//--- verif/mem_subsystem_vectors.txt
# op (bit0 load, bit1 store, bit2 alu) addr wdata, then outputs expected one cycle later:
# stall mem_write mem_write_addr mem_write_data load_valid load_data, all in hex
1 05 00000000 0 0 00 00000000 1 00000000
1 3f 00000000 0 0 00 00000000 1 00000000
0 00 00000000 0 0 00 00000000 0 00000000
2 10 11110001 0 0 00 00000000 0 00000000
2 11 22220002 0 0 00 00000000 0 00000000
1 10 00000000 0 0 00 00000000 1 11110001
2 10 33330003 0 0 00 00000000 0 00000000
1 10 00000000 0 0 00 00000000 1 33330003
2 12 44440004 0 0 00 00000000 0 00000000
2 13 55550005 1 1 10 11110001 0 00000000
1 13 00000000 0 0 00 00000000 1 55550005
4 00 00000000 0 1 11 22220002 0 00000000
4 00 00000000 0 1 10 33330003 0 00000000
1 10 00000000 0 0 00 00000000 1 33330003
4 00 00000000 0 1 12 44440004 0 00000000
4 00 00000000 0 1 13 55550005 0 00000000
4 00 00000000 0 0 00 00000000 0 00000000
1 10 00000000 0 0 00 00000000 1 33330003
1 11 00000000 0 0 00 00000000 1 22220002
1 13 00000000 0 0 00 00000000 1 55550005
1 12 00000000 0 0 00 00000000 1 44440004
3 20 deadbeef 0 0 00 00000000 1 00000000
1 20 00000000 0 0 00 00000000 1 00000000
0 00 00000000 0 0 00 00000000 0 00000000
2 22 77770007 0 0 00 00000000 0 00000000
5 22 00000000 0 0 00 00000000 1 77770007
4 00 00000000 0 1 22 77770007 0 00000000
0 00 00000000 0 0 00 00000000 0 00000000
